// File: dma_pkg.sv
`default_nettype none

package dma_pkg;

   // Channel count of the DMA block
   localparam int num_channels = 4;

   // Control word layout
   localparam int ctrl_count_lsb    = 0;
   localparam int ctrl_dst_mode_lsb = 21;
   localparam int ctrl_src_mode_lsb = 23;
   localparam int ctrl_repeat       = 25;
   localparam int ctrl_word32       = 26;
   localparam int ctrl_hblank_start = 28;
   localparam int ctrl_irq_en       = 30;
   localparam int ctrl_enable       = 31;

   // Address step after each unit
   // Code 3 (reload) is not supported and behaves as fixed
   typedef enum logic [1:0] {
      mode_inc   = 2'd0,
      mode_dec   = 2'd1,
      mode_fixed = 2'd2
   } addr_mode_t;

   // Register selector of the programming strobe
   typedef enum logic [1:0] {
      sel_src  = 2'd0,
      sel_dst  = 2'd1,
      sel_ctrl = 2'd2
   } reg_sel_t;

endpackage

`default_nettype wire

// File: dma_channel.sv
`default_nettype none

module dma_channel
   import dma_pkg::*;
#(
   parameter int mem_words = 1024,
   localparam int aw = $clog2(mem_words) + 2
) (
   input  logic          clk,
   input  logic          rst_n,
   input  logic          reg_wr,
   input  reg_sel_t      reg_sel,
   input  logic [31:0]   reg_wdata,
   input  logic          hblank,
   input  logic          step,
   output logic          req,
   output logic [aw-1:0] src_addr,
   output logic [aw-1:0] dst_addr,
   output logic          word32,
   output addr_mode_t    src_mode,
   output addr_mode_t    dst_mode,
   output logic          irq_en,
   output logic          last_unit
);

   logic [31:0] ctrl;
   logic [15:0] count;
   logic        active;
   logic        hb_pend;
   logic        ctrl_wr;
   logic        enable;
   logic        rpt;
   logic        hb_start;
   logic        hb_hit;
   logic        done;

   // Byte address after one unit, per mode and unit size
   function automatic logic [aw-1:0] next_addr(logic [aw-1:0] addr, addr_mode_t mode,
                                               logic wide);
      logic [aw-1:0] delta;
      delta = wide ? aw'(4) : aw'(2);
      case (mode)
         mode_inc: next_addr = addr + delta;
         mode_dec: next_addr = addr - delta;
         default:  next_addr = addr;
      endcase
   endfunction

   assign ctrl_wr  = reg_wr && (reg_sel == sel_ctrl);
   assign enable   = ctrl[ctrl_enable];
   assign rpt      = ctrl[ctrl_repeat];
   assign hb_start = ctrl[ctrl_hblank_start];
   assign word32   = ctrl[ctrl_word32];
   assign irq_en   = ctrl[ctrl_irq_en];
   assign src_mode = addr_mode_t'(ctrl[ctrl_src_mode_lsb +: 2]);
   assign dst_mode = addr_mode_t'(ctrl[ctrl_dst_mode_lsb +: 2]);

   assign hb_hit    = hblank && enable && hb_start;
   assign last_unit = active && (count == 16'd1);
   assign done      = step && last_unit;
   assign req       = active;

   // Control word, run flag and queued hblank start
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ctrl    <= '0;
         active  <= 1'b0;
         hb_pend <= 1'b0;
      end else if (ctrl_wr) begin
         ctrl    <= reg_wdata;
         active  <= reg_wdata[ctrl_enable] && !reg_wdata[ctrl_hblank_start];
         hb_pend <= 1'b0;
      end else if (done) begin
         // Repeat waits for the next hblank, one that already came is served now
         active  <= rpt && (hb_pend || hb_hit);
         hb_pend <= 1'b0;
         if (!rpt) begin
            ctrl[ctrl_enable] <= 1'b0;
         end
      end else if (hb_hit) begin
         if (active) begin
            hb_pend <= 1'b1;
         end else begin
            active <= 1'b1;
         end
      end
   end

   // Working addresses and remaining count
   always_ff @(posedge clk) begin
      if (reg_wr && (reg_sel == sel_src)) begin
         src_addr <= reg_wdata[aw-1:0];
      end else if (step) begin
         src_addr <= next_addr(src_addr, src_mode, word32);
      end

      if (reg_wr && (reg_sel == sel_dst)) begin
         dst_addr <= reg_wdata[aw-1:0];
      end else if (step) begin
         dst_addr <= next_addr(dst_addr, dst_mode, word32);
      end

      // A count of zero wraps through 16'hffff and so runs 65536 units
      if (ctrl_wr) begin
         count <= reg_wdata[ctrl_count_lsb +: 16];
      end else if (step) begin
         count <= last_unit ? ctrl[ctrl_count_lsb +: 16] : count - 16'd1;
      end
   end

endmodule

`default_nettype wire

// File: dma_ctrl.sv
`default_nettype none

module dma_ctrl
   import dma_pkg::*;
#(
   parameter int mem_words = 1024,
   localparam int aw = $clog2(mem_words) + 2,
   localparam int cw = $clog2(num_channels)
) (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             reg_wr,
   input  logic [cw-1:0]                    reg_ch,
   input  logic [num_channels-1:0]          req,
   input  logic [num_channels-1:0][aw-1:0]  src_addr,
   input  logic [num_channels-1:0][aw-1:0]  dst_addr,
   input  logic [num_channels-1:0]          word32,
   input  logic [num_channels-1:0]          irq_en,
   input  logic [num_channels-1:0]          last_unit,
   output logic [num_channels-1:0]          reg_wr_ch,
   output logic [num_channels-1:0]          step,
   output logic [num_channels-1:0]          irq,
   output logic                             busy,
   output logic                             dma_rd,
   output logic [aw-3:0]                    dma_rd_addr,
   output logic                             dma_wr,
   output logic [aw-1:0]                    unit_src,
   output logic [aw-1:0]                    unit_dst,
   output logic                             unit_word32
);

   typedef enum logic [1:0] {
      st_idle,
      st_read,
      st_write
   } state_t;

   state_t                  state;
   state_t                  state_nx;
   logic [cw-1:0]           gnt;
   logic [cw-1:0]           gnt_nx;
   logic [num_channels-1:0] finish;
   logic [num_channels-1:0] req_live;

   // Lowest-numbered requester wins
   function automatic logic [cw-1:0] pick(logic [num_channels-1:0] r);
      logic [cw-1:0] idx;
      idx = '0;
      for (int i = num_channels - 1; i >= 0; i--) begin
         if (r[i]) begin
            idx = cw'(i);
         end
      end
      return idx;
   endfunction

   // Register strobe decoded per channel
   always_comb begin
      reg_wr_ch         = '0;
      reg_wr_ch[reg_ch] = reg_wr;
   end

   // Step pulse for the granted channel in the write cycle
   always_comb begin
      step      = '0;
      step[gnt] = (state == st_write);
   end

   // A channel finishing now drops req only at the next edge
   assign finish   = step & last_unit;
   assign req_live = req & ~finish;

   // Unit sequencer, arbitration after every unit
   always_comb begin
      state_nx = state;
      gnt_nx   = gnt;
      case (state)
         st_idle: begin
            if (|req) begin
               state_nx = st_read;
               gnt_nx   = pick(req);
            end
         end
         st_read: begin
            state_nx = st_write;
         end
         st_write: begin
            if (|req_live) begin
               state_nx = st_read;
               gnt_nx   = pick(req_live);
            end else begin
               state_nx = st_idle;
            end
         end
         default: begin
            state_nx = st_idle;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= st_idle;
         gnt   <= '0;
         irq   <= '0;
      end else begin
         state <= state_nx;
         gnt   <= gnt_nx;
         // Pulse in the cycle after the last write
         irq   <= finish & irq_en;
      end
   end

   assign busy   = (state != st_idle);
   assign dma_rd = (state == st_read);
   assign dma_wr = (state == st_write);

   // Addresses and size of the granted channel
   assign unit_src    = src_addr[gnt];
   assign unit_dst    = dst_addr[gnt];
   assign unit_word32 = word32[gnt];
   assign dma_rd_addr = unit_src[aw-1:2];

endmodule

`default_nettype wire

// File: dma_lane_align.sv
`default_nettype none

module dma_lane_align #(
   parameter int mem_words = 1024,
   localparam int aw = $clog2(mem_words) + 2
) (
   input  logic [aw-1:0] unit_src,
   input  logic [aw-1:0] unit_dst,
   input  logic          unit_word32,
   input  logic          dma_wr,
   input  logic [31:0]   rd_data,
   output logic [aw-3:0] wr_addr,
   output logic [31:0]   wr_data,
   output logic [3:0]    wr_be,
   output logic          wr_en
);

   logic [15:0] half;
   logic [3:0]  lanes;

   // Source halfword picked by address bit 1
   assign half = unit_src[1] ? rd_data[31:16] : rd_data[15:0];

   always_comb begin
      if (unit_word32) begin
         wr_data = rd_data;
         lanes   = 4'b1111;
      end else begin
         // Both lanes carry the halfword, the enables pick the target
         wr_data = {half, half};
         lanes   = unit_dst[1] ? 4'b1100 : 4'b0011;
      end
   end

   // Enables only during the unit's write cycle
   assign wr_be   = dma_wr ? lanes : 4'b0000;
   assign wr_en   = dma_wr;
   assign wr_addr = unit_dst[aw-1:2];

endmodule

`default_nettype wire

// File: dma_ram.sv
`default_nettype none

module dma_ram #(
   parameter int mem_words = 1024,
   localparam int wa = $clog2(mem_words)
) (
   input  logic          clk,
   input  logic          rst_n,
   input  logic          busy,
   input  logic          dma_rd,
   input  logic [wa-1:0] dma_rd_addr,
   input  logic          wr_en,
   input  logic [wa-1:0] wr_addr,
   input  logic [31:0]   wr_data,
   input  logic [3:0]    wr_be,
   input  logic          host_wr,
   input  logic          host_rd,
   input  logic [wa-1:0] host_addr,
   input  logic [31:0]   host_wdata,
   output logic [31:0]   rd_data,
   output logic [31:0]   host_rdata
);

   logic [31:0]   mem [mem_words];
   logic [31:0]   q;
   logic [wa-1:0] addr;
   logic [31:0]   wdata;
   logic [3:0]    be;
   logic          host_rd_ok;
   logic          host_wr_ok;
   logic          rd_en;

   // Host is locked out while the DMA runs
   assign host_rd_ok = host_rd && !busy;
   assign host_wr_ok = host_wr && !busy;
   assign rd_en      = dma_rd || host_rd_ok;

   // Single port shared between DMA and host
   always_comb begin
      if (wr_en) begin
         addr  = wr_addr;
         wdata = wr_data;
         be    = wr_be;
      end else if (dma_rd) begin
         addr  = dma_rd_addr;
         wdata = wr_data;
         be    = 4'b0000;
      end else begin
         addr  = host_addr;
         wdata = host_wdata;
         be    = host_wr_ok ? 4'b1111 : 4'b0000;
      end
   end

   always_ff @(posedge clk) begin
      for (int b = 0; b < 4; b++) begin
         if (be[b]) begin
            mem[addr][8*b +: 8] <= wdata[8*b +: 8];
         end
      end
   end

   // Read register holds its value between reads
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         q <= '0;
      end else if (rd_en) begin
         q <= mem[addr];
      end
   end

   assign rd_data    = q;
   assign host_rdata = q;

endmodule

`default_nettype wire

// File: dma_top.sv
`default_nettype none

module dma_top
   import dma_pkg::*;
#(
   parameter int mem_words = 1024,
   localparam int aw = $clog2(mem_words) + 2,
   localparam int wa = $clog2(mem_words),
   localparam int cw = $clog2(num_channels)
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    reg_wr,
   input  logic [cw-1:0]           reg_ch,
   input  reg_sel_t                reg_sel,
   input  logic [31:0]             reg_wdata,
   input  logic                    hblank,
   input  logic                    host_wr,
   input  logic                    host_rd,
   input  logic [wa-1:0]           host_addr,
   input  logic [31:0]             host_wdata,
   output logic [31:0]             host_rdata,
   output logic [num_channels-1:0] irq,
   output logic                    busy
);

   logic [num_channels-1:0]         reg_wr_ch;
   logic [num_channels-1:0]         req;
   logic [num_channels-1:0]         step;
   logic [num_channels-1:0]         word32;
   logic [num_channels-1:0]         irq_en;
   logic [num_channels-1:0]         last_unit;
   logic [num_channels-1:0][aw-1:0] src_addr;
   logic [num_channels-1:0][aw-1:0] dst_addr;
   logic                            dma_rd;
   logic                            dma_wr;
   logic [wa-1:0]                   dma_rd_addr;
   logic [aw-1:0]                   unit_src;
   logic [aw-1:0]                   unit_dst;
   logic                            unit_word32;
   logic [wa-1:0]                   wr_addr;
   logic [31:0]                     wr_data;
   logic [3:0]                      wr_be;
   logic                            wr_en;
   logic [31:0]                     rd_data;

   for (genvar c = 0; c < num_channels; c++) begin : g_ch
      // Address modes are applied inside the channel
      dma_channel #(.mem_words(mem_words)) u_ch (
         .clk       (clk),
         .rst_n     (rst_n),
         .reg_wr    (reg_wr_ch[c]),
         .reg_sel   (reg_sel),
         .reg_wdata (reg_wdata),
         .hblank    (hblank),
         .step      (step[c]),
         .req       (req[c]),
         .src_addr  (src_addr[c]),
         .dst_addr  (dst_addr[c]),
         .word32    (word32[c]),
         .src_mode  (),
         .dst_mode  (),
         .irq_en    (irq_en[c]),
         .last_unit (last_unit[c])
      );
   end

   dma_ctrl #(.mem_words(mem_words)) u_ctrl (
      .clk         (clk),
      .rst_n       (rst_n),
      .reg_wr      (reg_wr),
      .reg_ch      (reg_ch),
      .req         (req),
      .src_addr    (src_addr),
      .dst_addr    (dst_addr),
      .word32      (word32),
      .irq_en      (irq_en),
      .last_unit   (last_unit),
      .reg_wr_ch   (reg_wr_ch),
      .step        (step),
      .irq         (irq),
      .busy        (busy),
      .dma_rd      (dma_rd),
      .dma_rd_addr (dma_rd_addr),
      .dma_wr      (dma_wr),
      .unit_src    (unit_src),
      .unit_dst    (unit_dst),
      .unit_word32 (unit_word32)
   );

   dma_lane_align #(.mem_words(mem_words)) u_align (
      .unit_src    (unit_src),
      .unit_dst    (unit_dst),
      .unit_word32 (unit_word32),
      .dma_wr      (dma_wr),
      .rd_data     (rd_data),
      .wr_addr     (wr_addr),
      .wr_data     (wr_data),
      .wr_be       (wr_be),
      .wr_en       (wr_en)
   );

   dma_ram #(.mem_words(mem_words)) u_ram (
      .clk         (clk),
      .rst_n       (rst_n),
      .busy        (busy),
      .dma_rd      (dma_rd),
      .dma_rd_addr (dma_rd_addr),
      .wr_en       (wr_en),
      .wr_addr     (wr_addr),
      .wr_data     (wr_data),
      .wr_be       (wr_be),
      .host_wr     (host_wr),
      .host_rd     (host_rd),
      .host_addr   (host_addr),
      .host_wdata  (host_wdata),
      .rd_data     (rd_data),
      .host_rdata  (host_rdata)
   );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
   output logic clk,
   output logic rst_n
);

   // Period of 100 time units
   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Reset held low for two cycles, released away from the edge
   initial begin
      rst_n = 1'b0;
      repeat (2) @(posedge clk);
      #10;
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

// File: dma_checker.sv
`default_nettype none

module dma_checker (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             busy,
   input  logic [3:0]       irq,
   input  logic             host_rd,
   input  logic [9:0]       host_addr,
   input  logic [31:0]      host_rdata,
   input  logic [31:0]      exp_data,
   input  logic [3:0]       test_id,
   input  logic [3:0]       irq_allow,
   input  logic             check_irq,
   input  logic [3:0][15:0] exp_cnt,
   input  logic             order_en,
   input  logic [1:0]       first_ch,
   input  logic [1:0]       second_ch,
   output logic [3:0][15:0] irq_cnt,
   output int               err_count
);

   logic        pend;
   logic [31:0] pend_exp;
   logic [9:0]  pend_addr;
   logic        reset_checked;
   int          cycle;
   int          stamp [4];

   function automatic string test_name(logic [3:0] id);
      case (id)
         4'd1:    return "word_copy";
         4'd2:    return "halfword_copy";
         4'd3:    return "addr_modes";
         4'd4:    return "priority";
         4'd5:    return "hblank_repeat";
         4'd6:    return "host_lockout";
         default: return "setup";
      endcase
   endfunction

   always_ff @(posedge clk or negedge rst_n) begin
      int errs;
      errs = 0;
      if (!rst_n) begin
         pend          <= 1'b0;
         pend_exp      <= '0;
         pend_addr     <= '0;
         irq_cnt       <= '0;
         err_count     <= 0;
         reset_checked <= 1'b0;
         cycle         <= 0;
         for (int c = 0; c < 4; c++) begin
            stamp[c] <= 0;
         end
      end else begin
         cycle     <= cycle + 1;
         // Read data shows up one cycle after the request
         pend      <= host_rd && !busy;
         pend_exp  <= exp_data;
         pend_addr <= host_addr;

         if (!reset_checked) begin
            reset_checked <= 1'b1;
            if (irq != 4'b0000 || busy) begin
               $display("Interrupt or busy was high right after reset");
               errs++;
            end
         end
         if (host_rd && busy) begin
            $display("Host read in test %s issued while the DMA was busy",
                     test_name(test_id));
            errs++;
         end
         if (pend && host_rdata !== pend_exp) begin
            $display("Fail %s word %0d expected %h actual %h",
                     test_name(test_id), pend_addr, pend_exp, host_rdata);
            errs++;
         end

         for (int c = 0; c < 4; c++) begin
            if (irq[c]) begin
               irq_cnt[c] <= irq_cnt[c] + 16'd1;
               stamp[c]   <= cycle;
               if (!irq_allow[c]) begin
                  $display("Unexpected interrupt on channel %0d in test %s",
                           c, test_name(test_id));
                  errs++;
               end
            end
         end

         if (check_irq) begin
            for (int c = 0; c < 4; c++) begin
               if (irq_cnt[c] < exp_cnt[c]) begin
                  $display("Missing interrupt on channel %0d in test %s",
                           c, test_name(test_id));
                  errs++;
               end else if (irq_cnt[c] > exp_cnt[c]) begin
                  $display("Extra interrupt on channel %0d in test %s",
                           c, test_name(test_id));
                  errs++;
               end
            end
            if (order_en && !(stamp[first_ch] < stamp[second_ch])) begin
               $display("Interrupt of channel %0d did not come before channel %0d",
                        first_ch, second_ch);
               errs++;
            end
         end
         err_count <= err_count + errs;
      end
   end

endmodule

`default_nettype wire

// File: dma_tb.sv
`default_nettype none

module dma_tb
   import dma_pkg::*;
();

   localparam int words_used = 256;
   // Twice the sum of 2 x units + 20 over the six tests
   localparam int timeout_cycles = 2 * ((2 * 8 + 20) + (2 * 6 + 20) + (2 * 8 + 20) +
                                        (2 * 31 + 20) + (2 * 12 + 20) + (2 * 16 + 20));

   logic             clk;
   logic             rst_n;
   logic             reg_wr;
   logic [1:0]       reg_ch;
   reg_sel_t         reg_sel;
   logic [31:0]      reg_wdata;
   logic             hblank;
   logic             host_wr;
   logic             host_rd;
   logic [9:0]       host_addr;
   logic [31:0]      host_wdata;
   logic [31:0]      host_rdata;
   logic [3:0]       irq;
   logic             busy;
   logic [31:0]      exp_data;
   logic [3:0]       test_id;
   logic [3:0]       irq_allow;
   logic             check_irq;
   logic [3:0][15:0] exp_cnt;
   logic [3:0][15:0] irq_cnt;
   logic             order_en;
   logic [1:0]       first_ch;
   logic [1:0]       second_ch;
   int               err_count;
   logic [31:0]      mirror [1024];
   logic             waiting;
   int               wait_cycles = 0;
   logic [11:0]      src;
   logic [11:0]      dst;
   logic [31:0]      ctrl;

   tb_clock_gen clk_gen (.clk(clk), .rst_n(rst_n));

   dma_top #(.mem_words(1024)) dut0 (
      .clk(clk), .rst_n(rst_n), .reg_wr(reg_wr), .reg_ch(reg_ch), .reg_sel(reg_sel),
      .reg_wdata(reg_wdata), .hblank(hblank), .host_wr(host_wr), .host_rd(host_rd),
      .host_addr(host_addr), .host_wdata(host_wdata), .host_rdata(host_rdata),
      .irq(irq), .busy(busy)
   );

   dma_checker chk (
      .clk(clk), .rst_n(rst_n), .busy(busy), .irq(irq), .host_rd(host_rd),
      .host_addr(host_addr), .host_rdata(host_rdata), .exp_data(exp_data),
      .test_id(test_id), .irq_allow(irq_allow), .check_irq(check_irq),
      .exp_cnt(exp_cnt), .order_en(order_en), .first_ch(first_ch),
      .second_ch(second_ch), .irq_cnt(irq_cnt), .err_count(err_count)
   );

   function automatic logic [31:0] make_ctrl(logic [15:0] count, addr_mode_t smode,
                                             addr_mode_t dmode, logic w32, logic hb,
                                             logic rpt, logic irqe);
      logic [31:0] c;
      c = '0;
      c[ctrl_count_lsb +: 16]   = count;
      c[ctrl_src_mode_lsb +: 2] = smode;
      c[ctrl_dst_mode_lsb +: 2] = dmode;
      c[ctrl_word32]            = w32;
      c[ctrl_hblank_start]      = hb;
      c[ctrl_repeat]            = rpt;
      c[ctrl_irq_en]            = irqe;
      c[ctrl_enable]            = 1'b1;
      return c;
   endfunction

   function automatic logic [11:0] moved(logic [11:0] a, logic [1:0] mode, logic [11:0] d);
      if (mode == 2'd0) begin
         return a + d;
      end else if (mode == 2'd1) begin
         return a - d;
      end
      return a;
   endfunction

   // Reference model of one run, applied to the mirror; addresses come back stepped
   function automatic void expected_mem(inout logic [11:0] s, inout logic [11:0] d,
                                        input logic [31:0] c);
      int          units;
      logic [11:0] delta;
      logic [31:0] w;
      logic [15:0] h;
      units = (c[ctrl_count_lsb +: 16] == 16'd0) ? 65536 : int'(c[ctrl_count_lsb +: 16]);
      delta = c[ctrl_word32] ? 12'd4 : 12'd2;
      for (int i = 0; i < units; i++) begin
         w = mirror[s[11:2]];
         if (c[ctrl_word32]) begin
            mirror[d[11:2]] = w;
         end else begin
            h = s[1] ? w[31:16] : w[15:0];
            if (d[1]) begin
               mirror[d[11:2]][31:16] = h;
            end else begin
               mirror[d[11:2]][15:0] = h;
            end
         end
         s = moved(s, c[ctrl_src_mode_lsb +: 2], delta);
         d = moved(d, c[ctrl_dst_mode_lsb +: 2], delta);
      end
   endfunction

   task automatic tick();
      @(posedge clk);
      #10;
   endtask

   task automatic write_reg(input logic [1:0] ch, input reg_sel_t sel, input logic [31:0] data);
      reg_wr    = 1'b1;
      reg_ch    = ch;
      reg_sel   = sel;
      reg_wdata = data;
      tick();
      reg_wr    = 1'b0;
   endtask

   task automatic start_channel(input logic [1:0] ch, input logic [11:0] s,
                                input logic [11:0] d, input logic [31:0] c);
      write_reg(ch, sel_src, {20'd0, s});
      write_reg(ch, sel_dst, {20'd0, d});
      write_reg(ch, sel_ctrl, c);
   endtask

   task automatic host_write(input logic [9:0] a, input logic [31:0] data);
      host_wr    = 1'b1;
      host_addr  = a;
      host_wdata = data;
      tick();
      host_wr    = 1'b0;
   endtask

   task automatic read_back();
      for (int a = 0; a < words_used; a++) begin
         host_rd   = 1'b1;
         host_addr = 10'(a);
         exp_data  = mirror[10'(a)];
         tick();
      end
      host_rd = 1'b0;
      tick();
   endtask

   task automatic check_counts();
      check_irq = 1'b1;
      tick();
      check_irq = 1'b0;
      order_en  = 1'b0;
   endtask

   task automatic wait_done();
      waiting = 1'b1;
      while (irq_cnt != exp_cnt || busy) begin
         tick();
      end
      waiting = 1'b0;
      check_counts();
   endtask

   task automatic pulse_hblank();
      hblank = 1'b1;
      tick();
      hblank = 1'b0;
   endtask

   // Run limit on cycles spent waiting for the DMA
   always @(posedge clk) begin
      if (waiting) begin
         wait_cycles++;
         if (wait_cycles >= timeout_cycles) begin
            $display("Timeout: the DMA did not finish within %0d cycles", timeout_cycles);
            $display("Errors: %0d, timeouts: 1", err_count);
            $display("TESTBENCH FAILED");
            $finish;
         end
      end
   end

   initial begin
      reg_wr     = 1'b0;
      reg_ch     = 2'd0;
      reg_sel    = sel_src;
      reg_wdata  = '0;
      hblank     = 1'b0;
      host_wr    = 1'b0;
      host_rd    = 1'b0;
      host_addr  = '0;
      host_wdata = '0;
      exp_data   = '0;
      test_id    = 4'd0;
      irq_allow  = 4'b0000;
      check_irq  = 1'b0;
      exp_cnt    = '0;
      order_en   = 1'b0;
      first_ch   = 2'd0;
      second_ch  = 2'd0;
      waiting    = 1'b0;
      void'($urandom(32'hf416_b5e1));
      @(posedge rst_n);
      tick();
      for (int a = 0; a < words_used; a++) begin
         mirror[10'(a)] = $urandom;
         host_write(10'(a), mirror[10'(a)]);
      end

      test_id   = 4'd1;
      irq_allow = 4'b0010;
      src  = 12'h000;
      dst  = 12'h100;
      ctrl = make_ctrl(16'd8, mode_inc, mode_inc, 1'b1, 1'b0, 1'b0, 1'b1);
      start_channel(2'd1, src, dst, ctrl);
      expected_mem(src, dst, ctrl);
      exp_cnt[1] = exp_cnt[1] + 16'd1;
      wait_done();
      read_back();

      // Upper source halfword into a lower destination halfword
      test_id   = 4'd2;
      irq_allow = 4'b1000;
      src  = 12'h042;
      dst  = 12'h180;
      ctrl = make_ctrl(16'd6, mode_inc, mode_inc, 1'b0, 1'b0, 1'b0, 1'b1);
      start_channel(2'd3, src, dst, ctrl);
      expected_mem(src, dst, ctrl);
      exp_cnt[3] = exp_cnt[3] + 16'd1;
      wait_done();
      read_back();

      test_id   = 4'd3;
      irq_allow = 4'b0011;
      src  = 12'h020;
      dst  = 12'h200;
      ctrl = make_ctrl(16'd4, mode_fixed, mode_inc, 1'b1, 1'b0, 1'b0, 1'b1);
      start_channel(2'd0, src, dst, ctrl);
      expected_mem(src, dst, ctrl);
      src  = 12'h03c;
      dst  = 12'h240;
      ctrl = make_ctrl(16'd4, mode_dec, mode_inc, 1'b1, 1'b0, 1'b0, 1'b1);
      start_channel(2'd1, src, dst, ctrl);
      expected_mem(src, dst, ctrl);
      exp_cnt[0] = exp_cnt[0] + 16'd1;
      exp_cnt[1] = exp_cnt[1] + 16'd1;
      wait_done();
      read_back();

      // Channel 1 runs without an interrupt
      test_id   = 4'd4;
      irq_allow = 4'b0101;
      src  = 12'h080;
      dst  = 12'h280;
      ctrl = make_ctrl(16'd24, mode_inc, mode_inc, 1'b1, 1'b0, 1'b0, 1'b1);
      start_channel(2'd2, src, dst, ctrl);
      expected_mem(src, dst, ctrl);
      repeat (3) tick();
      src  = 12'h0c0;
      dst  = 12'h2e0;
      ctrl = make_ctrl(16'd4, mode_inc, mode_inc, 1'b1, 1'b0, 1'b0, 1'b1);
      start_channel(2'd0, src, dst, ctrl);
      expected_mem(src, dst, ctrl);
      src  = 12'h0e0;
      dst  = 12'h300;
      ctrl = make_ctrl(16'd3, mode_inc, mode_inc, 1'b1, 1'b0, 1'b0, 1'b0);
      start_channel(2'd1, src, dst, ctrl);
      expected_mem(src, dst, ctrl);
      exp_cnt[0] = exp_cnt[0] + 16'd1;
      exp_cnt[2] = exp_cnt[2] + 16'd1;
      order_en  = 1'b1;
      first_ch  = 2'd0;
      second_ch = 2'd2;
      wait_done();
      read_back();

      test_id   = 4'd5;
      irq_allow = 4'b1000;
      src  = 12'h1a0;
      dst  = 12'h320;
      ctrl = make_ctrl(16'd4, mode_inc, mode_inc, 1'b1, 1'b1, 1'b1, 1'b1);
      start_channel(2'd3, src, dst, ctrl);
      repeat (5) tick();
      // Nothing moves before the first hblank
      check_counts();
      read_back();
      for (int p = 0; p < 3; p++) begin
         pulse_hblank();
         expected_mem(src, dst, ctrl);
         exp_cnt[3] = exp_cnt[3] + 16'd1;
         wait_done();
      end
      read_back();

      test_id   = 4'd6;
      irq_allow = 4'b0001;
      src  = 12'h000;
      dst  = 12'h3a0;
      ctrl = make_ctrl(16'd16, mode_inc, mode_inc, 1'b1, 1'b0, 1'b0, 1'b1);
      start_channel(2'd0, src, dst, ctrl);
      expected_mem(src, dst, ctrl);
      waiting = 1'b1;
      while (!busy) begin
         tick();
      end
      waiting = 1'b0;
      // Ignored by the memory, so the mirror keeps its value
      host_write(10'd250, ~mirror[10'd250]);
      exp_cnt[0] = exp_cnt[0] + 16'd1;
      wait_done();
      read_back();

      $display("Errors: %0d, timeouts: 0", err_count);
      if (err_count == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
dma_pkg.sv
dma_channel.sv
dma_ctrl.sv
dma_lane_align.sv
dma_ram.sv
dma_top.sv
tb_clock_gen.sv
dma_checker.sv
dma_tb.sv

// File: run_sim.sh
#!/bin/bash
# Build and run the DMA testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module dma_tb -f compile.f -Mdir obj_dir -o dma_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/dma_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "TESTBENCH PASSED" <<< "$output"; then
   exit 0
fi
exit 1
